/* hw/video_defs.svh */
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

////////////////////
// xga raster geometry
////////////////////

// horizontal, in pixel clocks
`define H_ACTIVE   1024
`define H_SYNC_ON  1047
`define H_SYNC_OFF 1183
`define H_TOTAL    1344

// vertical, in lines
`define V_ACTIVE   768
`define V_SYNC_ON  776
`define V_SYNC_OFF 782
`define V_TOTAL    806

// counter widths
`define HCOUNT_W 11
`define VCOUNT_W 10

////////////////////
// zbt memory
////////////////////

// 512k words of 36 bits
`define ADDR_W 19
`define WORD_W 36

// one stored pixel, two per word
`define PIX_W 18

////////////////////
// fetch pipeline
////////////////////

// columns the read address runs ahead of the raster
`define FETCH_LEAD 8

`endif

/* hw/video_pkg.sv */
`include "video_defs.svh"

package video_pkg;

   ////////////////////
   // raster state
   ////////////////////

   // one pixel position plus its sync and blank levels
   typedef struct packed {
      logic [`HCOUNT_W-1:0] hcount;
      logic [`VCOUNT_W-1:0] vcount;
      // active low
      logic                 hsync;
      // active low
      logic                 vsync;
      // high outside the active window
      logic                 blank;
   } raster_t;

   ////////////////////
   // memory side
   ////////////////////

   // write request from the pattern writer
   typedef struct packed {
      logic [`ADDR_W-1:0] addr;
      logic [`WORD_W-1:0] data;
   } mem_req_t;

   // one sram word, seen as two pixels by the display
   // and as four byte-plus-parity lanes by the pattern writer
   typedef union packed {
      // pix[1] is the even column, in the upper half
      logic [1:0][`PIX_W-1:0]   pix;
      logic [3:0][`WORD_W/4-1:0] lane;
   } vram_word_u;

   ////////////////////
   // colour
   ////////////////////

   // stored pixel format, red in the top bits
   typedef struct packed {
      logic [5:0] r;
      logic [5:0] g;
      logic [5:0] b;
   } rgb_t;

endpackage

/* hw/video_timing.sv */
`include "video_defs.svh"

module video_timing
   import video_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   output raster_t raster
);

   // pixel and line counters
   logic [`HCOUNT_W-1:0] hcount;
   logic [`VCOUNT_W-1:0] vcount;

   // registered levels, aligned with the counts
   logic hblank;
   logic vblank;
   logic hsync;
   logic vsync;
   logic blank;

   ////////////////////
   // count decodes
   ////////////////////

   logic hblank_on;
   logic hsync_on;
   logic hsync_off;
   logic hreset;
   logic vblank_on;
   logic vsync_on;
   logic vsync_off;
   logic vreset;
   logic next_hblank;
   logic next_vblank;

   assign hblank_on = (hcount == `HCOUNT_W'(`H_ACTIVE - 1));
   assign hsync_on  = (hcount == `HCOUNT_W'(`H_SYNC_ON));
   assign hsync_off = (hcount == `HCOUNT_W'(`H_SYNC_OFF));
   assign hreset    = (hcount == `HCOUNT_W'(`H_TOTAL - 1));

   // vertical events only fire on the last pixel of a line
   assign vblank_on = hreset && (vcount == `VCOUNT_W'(`V_ACTIVE - 1));
   assign vsync_on  = hreset && (vcount == `VCOUNT_W'(`V_SYNC_ON));
   assign vsync_off = hreset && (vcount == `VCOUNT_W'(`V_SYNC_OFF));
   assign vreset    = hreset && (vcount == `VCOUNT_W'(`V_TOTAL - 1));

   // blank state for the next cycle
   assign next_hblank = hreset ? 1'b0 : (hblank_on ? 1'b1 : hblank);
   assign next_vblank = vreset ? 1'b0 : (vblank_on ? 1'b1 : vblank);

   ////////////////////
   // counters and syncs
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         hcount <= '0;
         vcount <= '0;
         hblank <= 1'b0;
         vblank <= 1'b0;
         hsync  <= 1'b1;
         vsync  <= 1'b1;
         blank  <= 1'b0;
      end else begin
         hcount <= hreset ? '0 : hcount + 1'b1;
         if (hreset) begin
            vcount <= vreset ? '0 : vcount + 1'b1;
         end
         hblank <= next_hblank;
         vblank <= next_vblank;
         // syncs are active low
         if (hsync_on) begin
            hsync <= 1'b0;
         end else if (hsync_off) begin
            hsync <= 1'b1;
         end
         if (vsync_on) begin
            vsync <= 1'b0;
         end else if (vsync_off) begin
            vsync <= 1'b1;
         end
         // either blank for the next cycle blanks the pixel
         blank <= next_vblank | next_hblank;
      end
   end

   assign raster = '{hcount: hcount, vcount: vcount, hsync: hsync,
                     vsync: vsync, blank: blank};

endmodule

/* hw/bar_pattern_writer.sv */
`include "video_defs.svh"

module bar_pattern_writer
   import video_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     period_sel,
   output mem_req_t req
);

   // free running write address
   logic [`ADDR_W-1:0] count;

   // bar index placed in every lane
   logic [3:0] field;

   vram_word_u pattern;

   ////////////////////
   // address counter
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         count <= '0;
      end else begin
         count <= count + 1'b1;
      end
   end

   ////////////////////
   // lane data
   ////////////////////

   // short period uses bits 6..3, long period bits 7..4
   assign field = period_sel ? count[6:3] : count[7:4];

   always_comb begin
      pattern = '0;
      for (int i = 0; i < 4; i++) begin
         // field in the top of the lane, zeros below
         pattern.lane[i] = {field, {(`WORD_W / 4 - 4){1'b0}}};
      end
   end

   // request is valid every cycle
   assign req.addr = count;
   assign req.data = pattern;

endmodule

/* hw/zbt_controller.sv */
`include "video_defs.svh"

module zbt_controller
   import video_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  raster_t            raster,
   input  logic               write_en,
   input  mem_req_t           wreq,
   input  logic [`ADDR_W-1:0] read_addr,
   input  logic [`WORD_W-1:0] ram_rdata,
   output logic [`ADDR_W-1:0] ram_addr,
   output logic               ram_we_b,
   output logic [`WORD_W-1:0] ram_wdata,
   output logic               ram_wdata_oe,
   output vram_word_u         read_data
);

   // write owns the port during blanking
   logic wr_sel;

   // late-write data pipe, first stage sits with the address
   logic [`WORD_W-1:0] wdata_q;
   logic [`WORD_W-1:0] wdata_p1;

   // driver enable one stage behind ram_we_b
   logic oe_p1;

   assign wr_sel = raster.blank & write_en;

   ////////////////////
   // address and strobe
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         ram_addr     <= '0;
         ram_we_b     <= 1'b1;
         oe_p1        <= 1'b0;
         ram_wdata_oe <= 1'b0;
      end else begin
         ram_addr     <= wr_sel ? wreq.addr : read_addr;
         ram_we_b     <= ~wr_sel;
         // drivers on two cycles after the write address
         oe_p1        <= ~ram_we_b;
         ram_wdata_oe <= oe_p1;
      end
   end

   // write data trails its address by two cycles
   always_ff @(posedge clk) begin
      wdata_q   <= wreq.data;
      wdata_p1  <= wdata_q;
      ram_wdata <= wdata_p1;
   end

   // read word goes straight back to the fetch latches
   assign read_data = ram_rdata;

endmodule

/* hw/pixel_fetch.sv */
`include "video_defs.svh"

module pixel_fetch
   import video_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  raster_t            raster,
   input  vram_word_u         read_data,
   output logic [`ADDR_W-1:0] read_addr,
   output rgb_t               pixel
);

   // forecast position
   logic                 wrap;
   logic [`HCOUNT_W-1:0] fh;
   logic [`VCOUNT_W-1:0] fv;

   // returned word and the copy being shown
   vram_word_u word_latched;
   vram_word_u word_shown;

   ////////////////////
   // address forecast
   ////////////////////

   // forecast runs past the end of the line
   assign wrap = (raster.hcount >= `HCOUNT_W'(`H_TOTAL - `FETCH_LEAD));

   always_comb begin
      if (wrap) begin
         fh = raster.hcount - `HCOUNT_W'(`H_TOTAL - `FETCH_LEAD);
         // last line wraps to the top of the frame
         if (raster.vcount == `VCOUNT_W'(`V_TOTAL - 1)) begin
            fv = '0;
         end else begin
            fv = raster.vcount + 1'b1;
         end
      end else begin
         fh = raster.hcount + `HCOUNT_W'(`FETCH_LEAD);
         fv = raster.vcount;
      end
   end

   // two pixels per word, so column bit 0 drops out
   // forecast register plus controller register plus two-cycle read
   // puts word g on the bus at columns g-4 and g-3
   always_ff @(posedge clk) begin
      if (rst) begin
         read_addr <= '0;
      end else begin
         read_addr <= {fv, fh[`ADDR_W-`VCOUNT_W:1]};
      end
   end

   ////////////////////
   // word latches
   ////////////////////

   // both update on odd columns
   // latched holds word g over g-2..g-1, shown over g..g+1
   always_ff @(posedge clk) begin
      if (raster.hcount[0]) begin
         word_latched <= read_data;
         word_shown   <= word_latched;
      end
   end

   ////////////////////
   // pixel select
   ////////////////////

   // even column takes the upper half
   assign pixel = raster.hcount[0] ? rgb_t'(word_shown.pix[0])
                                   : rgb_t'(word_shown.pix[1]);

endmodule

/* hw/pixel_output.sv */
module pixel_output
   import video_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  raster_t    raster,
   input  logic       test_bar_sel,
   input  rgb_t       pixel,
   output logic [7:0] vga_red,
   output logic [7:0] vga_green,
   output logic [7:0] vga_blue,
   output logic       vga_hsync,
   output logic       vga_vsync,
   output logic       vga_blank_b
);

   // grey vertical bars, 64 columns wide
   rgb_t bar;
   rgb_t rgb_q;

   assign bar.r = {raster.hcount[8:6], 3'b000};
   assign bar.g = {raster.hcount[8:6], 3'b000};
   assign bar.b = {raster.hcount[8:6], 3'b000};

   ////////////////////
   // output registers
   ////////////////////

   // colour in step with sync and blank
   always_ff @(posedge clk) begin
      rgb_q <= test_bar_sel ? bar : pixel;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         vga_hsync   <= 1'b1;
         vga_vsync   <= 1'b1;
         vga_blank_b <= 1'b0;
      end else begin
         vga_hsync   <= raster.hsync;
         vga_vsync   <= raster.vsync;
         vga_blank_b <= ~raster.blank;
      end
   end

   // dac takes 8 bits, low two tied off
   assign vga_red   = {rgb_q.r, 2'b00};
   assign vga_green = {rgb_q.g, 2'b00};
   assign vga_blue  = {rgb_q.b, 2'b00};

endmodule

/* hw/zbt_video_top.sv */
`include "video_defs.svh"

module zbt_video_top
   import video_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   // switches
   input  logic               test_bar_sel,
   input  logic               pattern_period_sel,
   input  logic               pattern_write_en,
   // vga dac
   output logic [7:0]         vga_red,
   output logic [7:0]         vga_green,
   output logic [7:0]         vga_blue,
   output logic               vga_hsync,
   output logic               vga_vsync,
   output logic               vga_blank_b,
   // zbt sram
   output logic [`ADDR_W-1:0] ram_addr,
   output logic               ram_we_b,
   output logic [`WORD_W-1:0] ram_wdata,
   output logic               ram_wdata_oe,
   input  logic [`WORD_W-1:0] ram_rdata
);

   raster_t            raster;
   mem_req_t           wreq;
   logic [`ADDR_W-1:0] read_addr;
   vram_word_u         read_data;
   rgb_t               pixel;

   ////////////////////
   // decode stage
   ////////////////////

   video_timing u_timing (
      .clk    (clk),
      .rst    (rst),
      .raster (raster)
   );

   ////////////////////
   // execute stage
   ////////////////////

   bar_pattern_writer u_writer (
      .clk        (clk),
      .rst        (rst),
      .period_sel (pattern_period_sel),
      .req        (wreq)
   );

   zbt_controller u_ctrl (
      .clk          (clk),
      .rst          (rst),
      .raster       (raster),
      .write_en     (pattern_write_en),
      .wreq         (wreq),
      .read_addr    (read_addr),
      .ram_rdata    (ram_rdata),
      .ram_addr     (ram_addr),
      .ram_we_b     (ram_we_b),
      .ram_wdata    (ram_wdata),
      .ram_wdata_oe (ram_wdata_oe),
      .read_data    (read_data)
   );

   ////////////////////
   // result stage
   ////////////////////

   pixel_fetch u_fetch (
      .clk       (clk),
      .rst       (rst),
      .raster    (raster),
      .read_data (read_data),
      .read_addr (read_addr),
      .pixel     (pixel)
   );

   pixel_output u_out (
      .clk          (clk),
      .rst          (rst),
      .raster       (raster),
      .test_bar_sel (test_bar_sel),
      .pixel        (pixel),
      .vga_red      (vga_red),
      .vga_green    (vga_green),
      .vga_blue     (vga_blue),
      .vga_hsync    (vga_hsync),
      .vga_vsync    (vga_vsync),
      .vga_blank_b  (vga_blank_b)
   );

endmodule

/* dv/zbt_sram_model.sv */
`include "video_defs.svh"

module zbt_sram_model (
   input  logic               clk,
   input  logic               rst,
   input  logic [`ADDR_W-1:0] ram_addr,
   input  logic               ram_we_b,
   input  logic [`WORD_W-1:0] ram_wdata,
   input  logic               ram_wdata_oe,
   output logic [`WORD_W-1:0] ram_rdata,
   // observed dut levels for the write checks
   input  logic               vga_blank_b,
   input  logic               write_en,
   input  logic               period_sel,
   output logic               fault
);

   timeunit 1ns;
   timeprecision 100ps;

   logic [`WORD_W-1:0] mem [0:(1 << `ADDR_W) - 1];

   // address and strobe pipe, d2 lines up with the late-write data
   logic [`ADDR_W-1:0] addr_d1;
   logic [`ADDR_W-1:0] addr_d2;
   logic               we_d1;
   logic               we_d2;
   // switch levels as the dut saw them
   logic               wen_q;
   logic [2:0]         psel_q;

   ////////////////////
   // fill pattern
   ////////////////////

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   // seed 90 mixed with the word address, two steps give 36 bits
   function automatic logic [`WORD_W-1:0] fill_word(input logic [`ADDR_W-1:0] addr);
      logic [31:0] s1;
      logic [31:0] s2;
      s1 = lcg_next(32'd90 ^ {13'd0, addr});
      s2 = lcg_next(s1);
      return {s1[31:14], s2[31:14]};
   endfunction

   // four lanes, bar index on top and five zeros below
   function automatic logic [`WORD_W-1:0] lane_word(input logic [`ADDR_W-1:0] addr,
                                                    input logic psel);
      logic [3:0] field;
      field = psel ? addr[6:3] : addr[7:4];
      return {4{field, 5'b00000}};
   endfunction

   task automatic report_write(input string name, input logic [35:0] expected,
                               input logic [35:0] actual);
      $display("FAILED at %0d ns: %s expected %0h got %0h", $time, name, expected, actual);
      fault = 1'b1;
   endtask

   initial begin
      fault = 1'b0;
      for (int a = 0; a < (1 << `ADDR_W); a++) begin
         mem[a] = fill_word(a);
      end
   end

   ////////////////////
   // two-cycle port
   ////////////////////

   always @(posedge clk) begin
      if (rst) begin
         we_d1 <= 1'b1;
         we_d2 <= 1'b1;
      end else begin
         we_d1 <= ram_we_b;
         we_d2 <= we_d1;
      end
      addr_d1 <= ram_addr;
      addr_d2 <= addr_d1;
      wen_q   <= write_en;
      psel_q  <= {psel_q[1:0], period_sel};
      // read word lands two cycles after its address
      ram_rdata <= mem[addr_d1];
      // late write, data two cycles behind the address
      if (!we_d2) begin
         mem[addr_d2] <= ram_wdata;
      end
   end

   ////////////////////
   // write checks
   ////////////////////

   // strobe only while the display is blanked
   assert property (@(posedge clk) disable iff (rst) !ram_we_b |-> !vga_blank_b)
      else report_write("vga_blank_b", 36'd0, $sampled(vga_blank_b));

   // no write at all with the writer switched off
   assert property (@(posedge clk) disable iff (rst) !ram_we_b |-> wen_q)
      else report_write("ram_we_b", 36'd1, $sampled(ram_we_b));

   // drivers on exactly while late-write data is due
   assert property (@(posedge clk) disable iff (rst) ram_wdata_oe == !we_d2)
      else report_write("ram_wdata_oe", $sampled(!we_d2), $sampled(ram_wdata_oe));

   assert property (@(posedge clk) disable iff (rst)
                    !we_d2 |-> (ram_wdata == lane_word(addr_d2, psel_q[2])))
      else report_write("ram_wdata", $sampled(lane_word(addr_d2, psel_q[2])),
                        $sampled(ram_wdata));

endmodule

/* dv/zbt_video_tb.sv */
`include "video_defs.svh"

module zbt_video_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int    CLK_PERIOD = 4;
   localparam int    RESET_CYCLES = 8;
   // three frames plus reset
   localparam longint WATCHDOG_NS =
      64'd3 * `H_TOTAL * `V_TOTAL * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

   logic               clk;
   logic               rst;
   logic               test_bar_sel;
   logic               pattern_period_sel;
   logic               pattern_write_en;
   logic [7:0]         vga_red;
   logic [7:0]         vga_green;
   logic [7:0]         vga_blue;
   logic               vga_hsync;
   logic               vga_vsync;
   logic               vga_blank_b;
   logic [`ADDR_W-1:0] ram_addr;
   logic               ram_we_b;
   logic [`WORD_W-1:0] ram_wdata;
   logic               ram_wdata_oe;
   logic [`WORD_W-1:0] ram_rdata;
   logic               write_fault;

   // position of the pixel now on the outputs
   logic                 tracking;
   logic [`HCOUNT_W-1:0] out_h;
   logic [`VCOUNT_W-1:0] out_v;
   int                   frame;
   // test bar switch as registered with the colour
   logic                 bar_q;

   // expected outputs
   logic               exp_hsync;
   logic               exp_vsync;
   logic               active;
   logic               check_pixel;
   logic [`WORD_W-1:0] word;
   logic [`PIX_W-1:0]  pix;
   logic [7:0]         exp_red;
   logic [7:0]         exp_green;
   logic [7:0]         exp_blue;

   zbt_video_top UUT (
      .clk                (clk),
      .rst                (rst),
      .test_bar_sel       (test_bar_sel),
      .pattern_period_sel (pattern_period_sel),
      .pattern_write_en   (pattern_write_en),
      .vga_red            (vga_red),
      .vga_green          (vga_green),
      .vga_blue           (vga_blue),
      .vga_hsync          (vga_hsync),
      .vga_vsync          (vga_vsync),
      .vga_blank_b        (vga_blank_b),
      .ram_addr           (ram_addr),
      .ram_we_b           (ram_we_b),
      .ram_wdata          (ram_wdata),
      .ram_wdata_oe       (ram_wdata_oe),
      .ram_rdata          (ram_rdata)
   );

   zbt_sram_model sram (
      .clk          (clk),
      .rst          (rst),
      .ram_addr     (ram_addr),
      .ram_we_b     (ram_we_b),
      .ram_wdata    (ram_wdata),
      .ram_wdata_oe (ram_wdata_oe),
      .ram_rdata    (ram_rdata),
      .vga_blank_b  (vga_blank_b),
      .write_en     (pattern_write_en),
      .period_sel   (pattern_period_sel),
      .fault        (write_fault)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic stop_run();
      $display("Simulation failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report_value(input string name, input logic [35:0] expected,
                               input logic [35:0] actual);
      $display("FAILED at %0d ns: %s expected %0h got %0h", $time, name, expected, actual);
      stop_run();
   endtask

   // returns on the falling edge where the outputs show this pixel
   task automatic wait_for(input int f, input int v, input int h);
      while (!(frame == f && out_v == v && out_h == h)) begin
         @(negedge clk);
      end
   endtask

   ////////////////////
   // output tracking
   ////////////////////

   // outputs lag the raster by one cycle, so count from the first cycle out of reset
   always @(posedge clk) begin
      bar_q <= test_bar_sel;
      if (rst) begin
         tracking <= 1'b0;
         out_h    <= '0;
         out_v    <= '0;
         frame    <= 0;
      end else begin
         tracking <= 1'b1;
         if (tracking) begin
            if (out_h == `H_TOTAL - 1) begin
               out_h <= '0;
               if (out_v == `V_TOTAL - 1) begin
                  out_v <= '0;
                  frame <= frame + 1;
               end else begin
                  out_v <= out_v + 1'b1;
               end
            end else begin
               out_h <= out_h + 1'b1;
            end
         end
      end
   end

   always_comb begin
      // syncs go low the cycle after their on count, back high after the off count
      exp_hsync = !(out_h > `H_SYNC_ON && out_h <= `H_SYNC_OFF);
      exp_vsync = !(out_v > `V_SYNC_ON && out_v <= `V_SYNC_OFF);
      active    = (out_h < `H_ACTIVE) && (out_v < `V_ACTIVE);
      // memory is only the preload until the writer starts, first line has no prefetch
      check_pixel = active && (bar_q || (frame == 0 && out_v != 0));
      word = sram.fill_word({out_v, out_h[9:1]});
      pix  = out_h[0] ? word[`PIX_W-1:0] : word[`WORD_W-1:`PIX_W];
      if (bar_q) begin
         exp_red = {out_h[8:6], 5'b00000};
         exp_green = exp_red;
         exp_blue  = exp_red;
      end else begin
         exp_red   = {pix[17:12], 2'b00};
         exp_green = {pix[11:6], 2'b00};
         exp_blue  = {pix[5:0], 2'b00};
      end
   end

   ////////////////////
   // output checks
   ////////////////////

   assert property (@(posedge clk) tracking |-> (vga_hsync == exp_hsync))
      else report_value("vga_hsync", $sampled(exp_hsync), $sampled(vga_hsync));

   assert property (@(posedge clk) tracking |-> (vga_vsync == exp_vsync))
      else report_value("vga_vsync", $sampled(exp_vsync), $sampled(vga_vsync));

   assert property (@(posedge clk) tracking |-> (vga_blank_b == active))
      else report_value("vga_blank_b", $sampled(active), $sampled(vga_blank_b));

   assert property (@(posedge clk) (tracking && check_pixel) |-> (vga_red == exp_red))
      else report_value("vga_red", $sampled(exp_red), $sampled(vga_red));

   assert property (@(posedge clk) (tracking && check_pixel) |-> (vga_green == exp_green))
      else report_value("vga_green", $sampled(exp_green), $sampled(vga_green));

   assert property (@(posedge clk) (tracking && check_pixel) |-> (vga_blue == exp_blue))
      else report_value("vga_blue", $sampled(exp_blue), $sampled(vga_blue));

   // model raises this on a bad write
   always @(posedge write_fault) begin
      stop_run();
   end

   ////////////////////
   // stimulus
   ////////////////////

   initial begin
      rst                = 1'b1;
      test_bar_sel       = 1'b0;
      pattern_period_sel = 1'b0;
      pattern_write_en   = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;
      // frame buffer shown on lines 1..383, bars from the hblank of 383 on
      wait_for(0, 383, 1100);
      test_bar_sel = 1'b1;
      // writer on from the last active line, long period
      wait_for(0, 767, 1100);
      pattern_write_en = 1'b1;
      // switch period mid-line, no write in flight
      wait_for(1, 384, 512);
      pattern_period_sel = 1'b1;
      wait_for(1, 700, 512);
      pattern_write_en = 1'b0;
      // run through the vertical blank with the writer off
      wait_for(2, 0, 16);
      if (write_fault) begin
         stop_run();
      end else begin
         $display("Simulation completed successfully");
         $finish;
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the run reached its end");
      stop_run();
   end

endmodule

/* filelist.f */
+incdir+hw
hw/video_pkg.sv
hw/video_timing.sv
hw/bar_pattern_writer.sv
hw/zbt_controller.sv
hw/pixel_fetch.sv
hw/pixel_output.sv
hw/zbt_video_top.sv
dv/zbt_sram_model.sv
dv/zbt_video_tb.sv
